// File: rvExec_defines.svh
`ifndef RV_EXEC_DEFINES_SVH
`define RV_EXEC_DEFINES_SVH

`define XLEN      32
`define REG_COUNT 32

// Wishbone byte addresses with the word selected by bits 7 to 2
`define ADDR_INSTR    8'h00
`define ADDR_PC       8'h04
`define ADDR_STATUS   8'h08
`define ADDR_REG_BASE 8'h80  // Register xN sits at base plus 4 times N

`endif

// File: rvExecPkg.sv
package rvExecPkg;

    typedef enum logic [6:0] {
        R_FORMAT = 7'b0110011,
        I_FORMAT = 7'b0010011,  // Register-immediate arithmetic
        LOAD     = 7'b0000011,
        STORE    = 7'b0100011,
        B_FORMAT = 7'b1100011,
        LUI      = 7'b0110111,
        AUIPC    = 7'b0010111,
        JAL      = 7'b1101111,
        JALR     = 7'b1100111,
        SYSTEM   = 7'b1110011,
        FENCE    = 7'b0001111
    } opcodeE;

    typedef enum logic [3:0] {
        ADD                            = 4'd0,
        SUB                            = 4'd1,
        LEFT_SHIFT_UNSIGNED            = 4'd2,
        RIGHT_SHIFT_UNSIGNED           = 4'd3,
        RIGHT_SHIFT_SIGNED             = 4'd4,
        LESS_THAN_SIGNED               = 4'd5,
        LESS_THAN_UNSIGNED             = 4'd6,
        GREATER_OR_EQUAL_THAN_SIGNED   = 4'd7,
        GREATER_OR_EQUAL_THAN_UNSIGNED = 4'd8,
        XOR                            = 4'd9,
        OR                             = 4'd10,
        AND                            = 4'd11
    } aluOpE;

    typedef enum logic [2:0] {
        NONE_REG   = 3'd0,
        INSTR_REG  = 3'd1,
        PC_REG     = 3'd2,
        STATUS_REG = 3'd3,
        GPR_REG    = 3'd4
    } busRegE;

endpackage

// File: aluControl.sv
module aluControl (
    input  rvExecPkg::opcodeE opcode,
    input  logic [2:0]        funct3,
    input  logic              bit30,
    output rvExecPkg::aluOpE  aluOp
);

    // Register and immediate forms share this table
    function automatic rvExecPkg::aluOpE arithOp(
        input logic [2:0] f3,
        input logic       subSel,
        input logic       sraSel
    );
        case (f3)
            3'b000: begin
                if (subSel) begin
                    arithOp = rvExecPkg::SUB;
                end else begin
                    arithOp = rvExecPkg::ADD;
                end
            end
            3'b001:  arithOp = rvExecPkg::LEFT_SHIFT_UNSIGNED;
            3'b010:  arithOp = rvExecPkg::LESS_THAN_SIGNED;
            3'b011:  arithOp = rvExecPkg::LESS_THAN_UNSIGNED;
            3'b100:  arithOp = rvExecPkg::XOR;
            3'b101: begin
                if (sraSel) begin
                    arithOp = rvExecPkg::RIGHT_SHIFT_SIGNED;
                end else begin
                    arithOp = rvExecPkg::RIGHT_SHIFT_UNSIGNED;
                end
            end
            3'b110:  arithOp = rvExecPkg::OR;
            3'b111:  arithOp = rvExecPkg::AND;
            default: arithOp = rvExecPkg::ADD;
        endcase
    endfunction

    always_comb begin
        aluOp = rvExecPkg::ADD;  // LUI, AUIPC, jumps and illegal opcodes
        case (opcode)
            rvExecPkg::R_FORMAT: aluOp = arithOp(funct3, bit30, bit30);
            rvExecPkg::I_FORMAT: aluOp = arithOp(funct3, 1'b0, bit30);  // No SUBI
            rvExecPkg::B_FORMAT: begin
                case (funct3)
                    3'b000:  aluOp = rvExecPkg::SUB;  // BEQ
                    3'b001:  aluOp = rvExecPkg::SUB;  // BNE
                    3'b100:  aluOp = rvExecPkg::LESS_THAN_SIGNED;
                    3'b101:  aluOp = rvExecPkg::GREATER_OR_EQUAL_THAN_SIGNED;
                    3'b110:  aluOp = rvExecPkg::LESS_THAN_UNSIGNED;
                    3'b111:  aluOp = rvExecPkg::GREATER_OR_EQUAL_THAN_UNSIGNED;
                    default: aluOp = rvExecPkg::ADD;
                endcase
            end
            default: aluOp = rvExecPkg::ADD;
        endcase
    end

    always_comb begin
        assert (!$isunknown(aluOp))
            else $error("aluControl: ALU operation is unknown");
    end

endmodule

// File: alu.sv
`include "rvExec_defines.svh"

module alu (
    input  logic [`XLEN-1:0] a,
    input  logic [`XLEN-1:0] b,
    input  rvExecPkg::aluOpE aluOp,
    output logic [`XLEN-1:0] result,
    output logic             zero
);

    logic [$clog2(`XLEN)-1:0] shamt;
    logic                     ltSigned;
    logic                     ltUnsigned;

    assign shamt      = b[$clog2(`XLEN)-1:0];  // Low five bits only
    assign ltSigned   = $signed(a) < $signed(b);
    assign ltUnsigned = a < b;

    always_comb begin
        case (aluOp)
            rvExecPkg::ADD:                  result = a + b;
            rvExecPkg::SUB:                  result = a - b;
            rvExecPkg::LEFT_SHIFT_UNSIGNED:  result = a << shamt;
            rvExecPkg::RIGHT_SHIFT_UNSIGNED: result = a >> shamt;
            rvExecPkg::RIGHT_SHIFT_SIGNED:   result = $signed(a) >>> shamt;
            rvExecPkg::LESS_THAN_SIGNED: begin
                result = {{(`XLEN-1){1'b0}}, ltSigned};
            end
            rvExecPkg::LESS_THAN_UNSIGNED: begin
                result = {{(`XLEN-1){1'b0}}, ltUnsigned};
            end
            rvExecPkg::GREATER_OR_EQUAL_THAN_SIGNED: begin
                result = {{(`XLEN-1){1'b0}}, !ltSigned};
            end
            rvExecPkg::GREATER_OR_EQUAL_THAN_UNSIGNED: begin
                result = {{(`XLEN-1){1'b0}}, !ltUnsigned};
            end
            rvExecPkg::XOR:                  result = a ^ b;
            rvExecPkg::OR:                   result = a | b;
            rvExecPkg::AND:                  result = a & b;
            default:                         result = '0;
        endcase
    end

    assign zero = (result == '0);  // BEQ and BNE look at this after SUB

endmodule

// File: regFile.sv
`include "rvExec_defines.svh"

module regFile (
    input  logic             clk,
    input  logic             arstN,
    input  logic [4:0]       rs1Addr,
    input  logic [4:0]       rs2Addr,
    output logic [`XLEN-1:0] rs1Data,
    output logic [`XLEN-1:0] rs2Data,
    input  logic [4:0]       hostAddr,
    output logic [`XLEN-1:0] hostRData,
    input  logic             we,
    input  logic [4:0]       wAddr,
    input  logic [`XLEN-1:0] wData
);

    logic [`XLEN-1:0] regs [`REG_COUNT];

    assign rs1Data   = regs[rs1Addr];
    assign rs2Data   = regs[rs2Addr];
    assign hostRData = regs[hostAddr];  // Bus read port

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wAddr != '0)) begin
            regs[wAddr] <= wData;  // x0 stays zero
        end
    end

    x0ReadsZero: assert property (@(posedge clk) disable iff (!arstN)
        ((rs1Addr != '0) || (rs1Data == '0)) &&
        ((rs2Addr != '0) || (rs2Data == '0)) &&
        ((hostAddr != '0) || (hostRData == '0)))
        else $error("regFile: x0 read back nonzero");

endmodule

// File: immGen.sv
`include "rvExec_defines.svh"

module immGen (
    input  logic [`XLEN-1:0] instr,
    output logic [`XLEN-1:0] imm
);

    rvExecPkg::opcodeE opcode;
    logic [`XLEN-1:0]  immI;
    logic [`XLEN-1:0]  immB;
    logic [`XLEN-1:0]  immU;
    logic [`XLEN-1:0]  immJ;

    assign opcode = rvExecPkg::opcodeE'(instr[6:0]);

    assign immI = {{20{instr[31]}}, instr[31:20]};
    assign immB = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign immU = {instr[31:12], 12'b0};
    assign immJ = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    // Bit 31 of the instruction is the sign in every format
    always_comb begin
        case (opcode)
            rvExecPkg::B_FORMAT: imm = immB;
            rvExecPkg::LUI,
            rvExecPkg::AUIPC:    imm = immU;
            rvExecPkg::JAL:      imm = immJ;
            default:             imm = immI;  // Immediate arithmetic, JALR, loads
        endcase
    end

endmodule

// File: execCore.sv
`include "rvExec_defines.svh"

module execCore (
    input  logic [`XLEN-1:0] instr,
    input  logic [`XLEN-1:0] pc,
    input  logic [`XLEN-1:0] rs1Data,
    input  logic [`XLEN-1:0] rs2Data,
    output logic [4:0]       rs1Addr,
    output logic [4:0]       rs2Addr,
    output logic             rdWe,
    output logic [4:0]       rdAddr,
    output logic [`XLEN-1:0] rdData,
    output logic [`XLEN-1:0] pcNext,
    output logic             illegal,
    output logic             branchTaken
);

    rvExecPkg::opcodeE opcode;
    rvExecPkg::aluOpE  aluOp;
    logic [2:0]        funct3;
    logic [`XLEN-1:0]  imm;
    logic [`XLEN-1:0]  opA;
    logic [`XLEN-1:0]  opB;
    logic [`XLEN-1:0]  aluResult;
    logic [`XLEN-1:0]  pcPlus4;
    logic [`XLEN-1:0]  branchTarget;
    logic              aluZero;
    logic              isBranch;
    logic              branchCond;

    assign opcode  = rvExecPkg::opcodeE'(instr[6:0]);
    assign funct3  = instr[14:12];
    assign rdAddr  = instr[11:7];
    assign rs1Addr = instr[19:15];
    assign rs2Addr = instr[24:20];

    assign pcPlus4      = pc + 'd4;
    assign branchTarget = pc + imm;

    aluControl aluControl_inst (.opcode, .funct3, .bit30(instr[30]), .aluOp);
    immGen     immGen_inst     (.instr, .imm);
    alu        alu_inst        (.a(opA), .b(opB), .aluOp, .result(aluResult), .zero(aluZero));

    always_comb begin
        case (opcode)
            rvExecPkg::AUIPC, rvExecPkg::JAL: opA = pc;
            rvExecPkg::LUI:                   opA = '0;  // Immediate passes through ADD
            default:                          opA = rs1Data;
        endcase
        case (opcode)
            rvExecPkg::R_FORMAT, rvExecPkg::B_FORMAT: opB = rs2Data;
            default:                                  opB = imm;
        endcase
    end

    always_comb begin
        case (funct3)
            3'b000:  branchCond = aluZero;   // BEQ
            3'b001:  branchCond = !aluZero;  // BNE
            default: branchCond = aluResult[0];
        endcase
    end

    assign isBranch    = (opcode == rvExecPkg::B_FORMAT);
    assign branchTaken = isBranch && branchCond;

    always_comb begin
        illegal = 1'b0;
        rdWe    = 1'b1;
        rdData  = aluResult;
        pcNext  = pcPlus4;
        case (opcode)
            rvExecPkg::R_FORMAT, rvExecPkg::I_FORMAT,
            rvExecPkg::LUI, rvExecPkg::AUIPC: rdData = aluResult;
            rvExecPkg::JAL: begin
                rdData = pcPlus4;
                pcNext = aluResult;
            end
            rvExecPkg::JALR: begin
                rdData = pcPlus4;
                pcNext = {aluResult[`XLEN-1:1], 1'b0};
            end
            rvExecPkg::B_FORMAT: begin
                rdWe   = 1'b0;
                pcNext = branchTaken ? branchTarget : pcPlus4;
            end
            default: begin
                illegal = 1'b1;  // Loads, stores, FENCE, SYSTEM, unknown
                rdWe    = 1'b0;
                pcNext  = pc;
            end
        endcase
    end

endmodule

// File: wbExecSlave.sv
`include "rvExec_defines.svh"

module wbExecSlave (
    input  logic             clk,
    input  logic             arstN,
    input  logic             wbCyc,
    input  logic             wbStb,
    input  logic             wbWe,
    input  logic [7:0]       wbAdr,
    input  logic [`XLEN-1:0] wbDatW,
    output logic [`XLEN-1:0] wbDatR,
    output logic             wbAck,
    output logic [`XLEN-1:0] instr,
    output logic [`XLEN-1:0] pc,
    output logic [4:0]       gprAddr,
    input  logic [`XLEN-1:0] gprRData,
    output logic             gprWe,
    output logic [`XLEN-1:0] gprWData,
    input  logic             rdWe,
    input  logic [4:0]       rdAddr,
    input  logic [`XLEN-1:0] rdData,
    input  logic [`XLEN-1:0] pcNext,
    input  logic             illegal,
    input  logic             branchTaken,
    output logic             wbRegWe,
    output logic [4:0]       wbRegAddr,
    output logic [`XLEN-1:0] wbRegData
);

    rvExecPkg::busRegE busReg;
    logic              waitState;  // Request seen and ack due on the next edge
    logic              reqStart;
    logic              hostWrite;
    logic              execStart;
    logic              illegalBit;
    logic              branchBit;

    always_comb begin
        if (wbAdr >= `ADDR_REG_BASE) begin
            busReg = rvExecPkg::GPR_REG;
        end else begin
            case ({wbAdr[7:2], 2'b00})
                `ADDR_INSTR:  busReg = rvExecPkg::INSTR_REG;
                `ADDR_PC:     busReg = rvExecPkg::PC_REG;
                `ADDR_STATUS: busReg = rvExecPkg::STATUS_REG;
                default:      busReg = rvExecPkg::NONE_REG;
            endcase
        end
    end

    assign reqStart  = wbCyc && wbStb && !waitState && !wbAck;
    assign hostWrite = reqStart && wbWe;

    assign gprAddr  = wbAdr[6:2];
    assign gprWe    = hostWrite && (busReg == rvExecPkg::GPR_REG);
    assign gprWData = wbDatW;

    // Host writes land on the first edge and core results on the ack edge
    assign wbRegWe   = gprWe || (execStart && rdWe);
    assign wbRegAddr = execStart ? rdAddr : gprAddr;
    assign wbRegData = execStart ? rdData : gprWData;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            waitState  <= 1'b0;
            wbAck      <= 1'b0;
            execStart  <= 1'b0;
            pc         <= '0;
            illegalBit <= 1'b0;
            branchBit  <= 1'b0;
        end else begin
            waitState <= reqStart;
            wbAck     <= waitState;
            execStart <= hostWrite && (busReg == rvExecPkg::INSTR_REG);
            if (execStart) begin
                pc         <= pcNext;
                illegalBit <= illegal;
                branchBit  <= branchTaken;
            end else if (hostWrite && (busReg == rvExecPkg::PC_REG)) begin
                pc <= wbDatW;
            end
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            instr <= '0;
        end else if (hostWrite && (busReg == rvExecPkg::INSTR_REG)) begin
            instr <= wbDatW;
        end
    end

    always_comb begin
        case (busReg)
            rvExecPkg::INSTR_REG:  wbDatR = instr;
            rvExecPkg::PC_REG:     wbDatR = pc;
            rvExecPkg::STATUS_REG: wbDatR = {{(`XLEN-2){1'b0}}, branchBit, illegalBit};
            rvExecPkg::GPR_REG:    wbDatR = gprRData;
            default:               wbDatR = '0;  // Unmapped reads return zero
        endcase
    end

    ackOneWaitState: assert property (@(posedge clk) disable iff (!arstN)
        wbAck |-> ($past(wbCyc && wbStb) && !$past(wbAck)))
        else $error("wbExecSlave: ack without request or held two cycles");

endmodule

// File: rvExecTop.sv
`include "rvExec_defines.svh"

module rvExecTop (
    input  logic             clk,
    input  logic             arstN,
    input  logic             wbCyc,
    input  logic             wbStb,
    input  logic             wbWe,
    input  logic [7:0]       wbAdr,
    input  logic [`XLEN-1:0] wbDatW,
    output logic [`XLEN-1:0] wbDatR,
    output logic             wbAck
);

    logic [`XLEN-1:0] instr;
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] pcNext;
    logic [4:0]       gprAddr;
    logic [`XLEN-1:0] gprRData;
    logic [4:0]       rs1Addr;
    logic [4:0]       rs2Addr;
    logic [`XLEN-1:0] rs1Data;
    logic [`XLEN-1:0] rs2Data;
    logic             rdWe;
    logic [4:0]       rdAddr;
    logic [`XLEN-1:0] rdData;
    logic             illegal;
    logic             branchTaken;
    logic             wbRegWe;
    logic [4:0]       wbRegAddr;
    logic [`XLEN-1:0] wbRegData;

    wbExecSlave wbExecSlave_inst (
        .clk, .arstN,
        .wbCyc, .wbStb, .wbWe, .wbAdr, .wbDatW, .wbDatR, .wbAck,
        .instr, .pc, .gprAddr, .gprRData,
        .gprWe(), .gprWData(),  // Already folded into the merged write port
        .rdWe, .rdAddr, .rdData, .pcNext, .illegal, .branchTaken,
        .wbRegWe, .wbRegAddr, .wbRegData
    );

    execCore execCore_inst (
        .instr, .pc, .rs1Data, .rs2Data, .rs1Addr, .rs2Addr,
        .rdWe, .rdAddr, .rdData, .pcNext, .illegal, .branchTaken
    );

    regFile regFile_inst (
        .clk, .arstN,
        .rs1Addr, .rs2Addr, .rs1Data, .rs2Data,
        .hostAddr(gprAddr), .hostRData(gprRData),
        .we(wbRegWe), .wAddr(wbRegAddr), .wData(wbRegData)
    );

endmodule

// File: rvExecTb.sv
`include "rvExec_defines.svh"

module rvExecTb;

    logic             clk;
    logic             arstN;
    logic             wbCyc;
    logic             wbStb;
    logic             wbWe;
    logic [7:0]       wbAdr;
    logic [`XLEN-1:0] wbDatW;
    logic [`XLEN-1:0] wbDatR;
    logic             wbAck;

    logic [`XLEN-1:0] shadowRegs [`REG_COUNT];
    logic [`XLEN-1:0] shadowPc;
    logic [1:0]       shadowStatus;  // Branch taken, illegal
    int               errors;
    int               timeouts;
    int               checks;

    rvExecTop rvExecTop_inst (
        .clk, .arstN, .wbCyc, .wbStb, .wbWe, .wbAdr, .wbDatW, .wbDatR, .wbAck
    );

    always #4 clk = ~clk;

    task automatic busAccess(input logic write, input logic [7:0] adr,
                             input logic [`XLEN-1:0] dataIn, output logic [`XLEN-1:0] dataOut);
        int cycles;
        cycles = 0;
        wbCyc  = 1'b1;
        wbStb  = 1'b1;
        wbWe   = write;
        wbAdr  = adr;
        wbDatW = dataIn;
        do begin
            @(negedge clk);
            cycles++;
        end while (!wbAck && cycles < 20);
        dataOut = wbDatR;
        if (!wbAck) begin
            $display("Timeout at %0t: no ack for address %h", $time, adr);
            timeouts++;
        end else if (cycles != 2) begin
            $display("Ack at %0t came after %0d cycles instead of 2", $time, cycles);
            errors++;
        end
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe  = 1'b0;
        @(negedge clk);  // Idle cycle between requests
    endtask

    task automatic busWrite(input logic [7:0] adr, input logic [`XLEN-1:0] data);
        logic [`XLEN-1:0] ignored;
        busAccess(1'b1, adr, data, ignored);
    endtask

    task automatic busRead(input logic [7:0] adr, output logic [`XLEN-1:0] data);
        busAccess(1'b0, adr, '0, data);
    endtask

    task automatic checkValue(input string name, input logic [`XLEN-1:0] got,
                              input logic [`XLEN-1:0] exp);
        checks++;
        if (got !== exp) begin
            $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    function automatic logic [`XLEN-1:0] refArith(input logic [2:0] f3, input logic alt,
                                                 input logic [`XLEN-1:0] a,
                                                 input logic [`XLEN-1:0] b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return {31'b0, $signed(a) < $signed(b)};
            3'b011:  return {31'b0, a < b};
            3'b100:  return a ^ b;
            3'b101: begin
                if (alt) begin
                    return $signed(a) >>> b[4:0];
                end
                return a >> b[4:0];
            end
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    // Advances the shadow registers, PC and status by one instruction
    function automatic void refExec(input logic [`XLEN-1:0] instr);
        logic [2:0]       f3;
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        logic [`XLEN-1:0] immI;
        logic [`XLEN-1:0] immB;
        logic [`XLEN-1:0] immU;
        logic [`XLEN-1:0] immJ;
        logic [`XLEN-1:0] result;
        logic [`XLEN-1:0] nextPc;
        logic             writeRd;
        logic             taken;
        f3      = instr[14:12];
        a       = shadowRegs[instr[19:15]];
        b       = shadowRegs[instr[24:20]];
        immI    = {{20{instr[31]}}, instr[31:20]};
        immB    = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
        immU    = {instr[31:12], 12'b0};
        immJ    = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
        nextPc  = shadowPc + 32'd4;
        result  = nextPc;  // Link value for jumps
        writeRd = 1'b1;
        taken   = 1'b0;
        shadowStatus = 2'b00;
        case (instr[6:0])
            rvExecPkg::R_FORMAT: result = refArith(f3, instr[30], a, b);
            rvExecPkg::I_FORMAT: result = refArith(f3, instr[30] && (f3 == 3'b101), a, immI);
            rvExecPkg::LUI:      result = immU;
            rvExecPkg::AUIPC:    result = shadowPc + immU;
            rvExecPkg::JAL:      nextPc = shadowPc + immJ;
            rvExecPkg::JALR:     nextPc = (a + immI) & ~32'd1;
            rvExecPkg::B_FORMAT: begin
                writeRd = 1'b0;
                case (f3)
                    3'b000:  taken = (a == b);
                    3'b001:  taken = (a != b);
                    3'b100:  taken = ($signed(a) < $signed(b));
                    3'b101:  taken = ($signed(a) >= $signed(b));
                    3'b110:  taken = (a < b);
                    default: taken = (a >= b);
                endcase
                if (taken) begin
                    nextPc = shadowPc + immB;
                end
            end
            default: begin
                writeRd         = 1'b0;
                nextPc          = shadowPc;
                shadowStatus[0] = 1'b1;
            end
        endcase
        shadowStatus[1] = taken;
        if (writeRd && (instr[11:7] != 5'd0)) begin
            shadowRegs[instr[11:7]] = result;
        end
        shadowPc = nextPc;
    endfunction

    function automatic logic [31:0] encodeI(input logic [11:0] imm, input logic [4:0] rs1,
                                            input logic [2:0] f3, input logic [4:0] rd,
                                            input logic [6:0] opcode);
        return {imm, rs1, f3, rd, opcode};  // R format words pass {funct7, rs2} as imm
    endfunction

    function automatic logic [31:0] encodeB(input logic [12:0] imm, input logic [4:0] rs2,
                                            input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rvExecPkg::B_FORMAT};
    endfunction

    function automatic logic [31:0] encodeJ(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rvExecPkg::JAL};
    endfunction

    task automatic setReg(input logic [4:0] idx, input logic [`XLEN-1:0] value);
        busWrite(`ADDR_REG_BASE + {1'b0, idx, 2'b00}, value);
        if (idx != 5'd0) begin
            shadowRegs[idx] = value;
        end
    endtask

    task automatic loadRandomRegs();
        for (int i = 0; i < `REG_COUNT; i++) begin
            setReg(5'(i), $urandom());  // x0 write must be ignored
        end
    endtask

    task automatic compareState();
        logic [`XLEN-1:0] data;
        for (int i = 0; i < `REG_COUNT; i++) begin
            busRead(`ADDR_REG_BASE + 8'(4 * i), data);
            checkValue($sformatf("x%0d", i), data, shadowRegs[i]);
        end
        busRead(`ADDR_PC, data);
        checkValue("pc", data, shadowPc);
        busRead(`ADDR_STATUS, data);
        checkValue("status", data, {30'b0, shadowStatus});
    endtask

    task automatic runInstr(input logic [31:0] instr);
        busWrite(`ADDR_INSTR, instr);
        refExec(instr);
        compareState();
    endtask

    initial begin
        logic [31:0] pairA [3] = '{32'd5, 32'hffff_fffd, 32'd7};
        logic [31:0] pairB [3] = '{32'd5, 32'd7, 32'hffff_fffd};
        logic [11:0] imm;
        void'($urandom(32'h7f26));
        clk    = 1'b0;
        arstN  = 1'b0;
        wbCyc  = 1'b0;
        wbStb  = 1'b0;
        wbWe   = 1'b0;
        wbAdr  = '0;
        wbDatW = '0;
        errors   = 0;
        timeouts = 0;
        checks   = 0;
        shadowPc     = '0;
        shadowStatus = '0;
        for (int i = 0; i < `REG_COUNT; i++) begin
            shadowRegs[i] = '0;
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;
        @(negedge clk);

        compareState();  // Reset values

        for (int f3 = 0; f3 < 8; f3++) begin
            for (int alt = 0; alt < 2; alt++) begin
                loadRandomRegs();
                runInstr(encodeI({1'b0, 1'(alt), 5'b0, 5'($urandom)}, 5'($urandom), 3'(f3),
                                 5'($urandom), rvExecPkg::R_FORMAT));
                if (f3 == 1 || f3 == 5) begin
                    imm = {1'b0, 1'(alt), 5'b0, 5'($urandom)};  // Shift amount form
                end else begin
                    imm = 12'($urandom);
                end
                runInstr(encodeI(imm, 5'($urandom), 3'(f3), 5'($urandom), rvExecPkg::I_FORMAT));
            end
        end
        runInstr(encodeI(12'd5, 5'd1, 3'b000, 5'd0, rvExecPkg::I_FORMAT));

        for (int p = 0; p < 3; p++) begin
            for (int f3 = 0; f3 < 8; f3++) begin
                if (f3 == 2 || f3 == 3) begin
                    continue;  // No branch on these codes
                end
                setReg(5'd1, pairA[p]);
                setReg(5'd2, pairB[p]);
                runInstr(encodeB({12'($urandom), 1'b0}, 5'd2, 5'd1, 3'(f3)));
            end
        end

        runInstr({20'($urandom), 5'd3, rvExecPkg::LUI});
        runInstr({20'($urandom), 5'd4, rvExecPkg::AUIPC});
        runInstr(encodeJ({20'($urandom), 1'b0}, 5'd5));
        setReg(5'd6, 32'h0000_1001);
        runInstr(encodeI(12'h0f2, 5'd6, 3'b000, 5'd7, rvExecPkg::JALR));  // Odd target
        runInstr(encodeI(12'h804, 5'd7, 3'b000, 5'd7, rvExecPkg::JALR));

        runInstr(encodeI(12'h010, 5'd1, 3'b010, 5'd8, rvExecPkg::LOAD));
        runInstr(encodeI(12'h010, 5'd1, 3'b010, 5'd9, rvExecPkg::STORE));
        runInstr(encodeI(12'h000, 5'd0, 3'b000, 5'd0, rvExecPkg::SYSTEM));

        $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+.
rvExecPkg.sv
aluControl.sv
alu.sv
regFile.sv
immGen.sv
execCore.sv
wbExecSlave.sv
rvExecTop.sv
rvExecTb.sv

// File: run.sh
#!/bin/sh
# Build with Verilator, run, then look for the pass message in the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module rvExecTb -f files.f -o rvExecSim \
    && ./obj_dir/rvExecSim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "ALL TESTS PASSED" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
